/* filelist.f */
logic/trace_pkg.sv
logic/trace_rec_if.sv
logic/trace_capture.sv
logic/trace_stamp_counter.sv
logic/trace_ctrl_fsm.sv
logic/trace_buffer.sv
logic/trace_wb_regs.sv
logic/trace_monitor_top.sv
testbench/tb_trace_monitor.sv

/* Makefile */
# Verilator build and run for the bus access tracer

VERILATOR ?= verilator
VFLAGS    := --binary --timing -j 0
LINTFLAGS := --lint-only --timing
TOP       := tb_trace_monitor
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Pass only when the log holds the pass line
sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/tb_trace_monitor.sv */
/*
 * Bus access tracer testbench
 * Random data bus traffic against a reference model, readout over Wishbone
 */

`timescale 1ns/10ps

module tb_trace_monitor;
  import trace_pkg::*;

  localparam int          PEND_DEPTH    = 4;
  localparam int          BUF_DEPTH     = 16;
  localparam logic [31:0] WIN_BASE_DEF  = 32'h0000_0000;
  localparam logic [31:0] WIN_RANGE_DEF = 32'h0000_4000;

  // Traffic lengths per phase, in cycles
  localparam int T_CAPTURE = 40;
  localparam int T_WINDOW  = 60;
  localparam int T_OVERLAP = 40;
  localparam int T_FULL    = 100;
  localparam int T_REARM   = 40;
  localparam int T_TOTAL   = T_CAPTURE + T_WINDOW + T_OVERLAP + T_FULL + T_REARM;
  // Seven readouts of up to a full buffer, 7 accesses per record, 4 cycles each
  localparam int MAX_CYCLES = 2 * T_TOTAL + 7 * (BUF_DEPTH * 7 + 12) * 4 + 200;

  logic              clk;
  logic              rst;
  logic              req;
  logic [XLEN-1:0]   adr;
  logic [XLEN-1:0]   d;
  logic              we;
  biu_size_t         size;
  logic [XLEN-1:0]   sp;
  logic [XLEN-1:0]   ra;
  logic              ack;
  logic [XLEN-1:0]   q;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [WB_AW-1:0]  wb_adr;
  logic [XLEN-1:0]   wb_dat_w;
  logic [XLEN-1:0]   wb_dat_r;
  logic              wb_ack;
  logic              irq;

  int cycle_cnt;
  int errors;

  // Model of the pending request queue
  logic [31:0] pend_adr[$];
  logic [31:0] pend_d[$];
  logic [31:0] pend_sp[$];
  logic [31:0] pend_ra[$];
  logic        pend_we[$];
  logic [1:0]  pend_size[$];
  int          pend_due[$];

  // Expected buffer contents since the last arm
  logic [31:0] exp_adr[$];
  logic [31:0] exp_data[$];
  logic [31:0] exp_sp[$];
  logic [31:0] exp_ra[$];
  logic [2:0]  exp_flags[$];
  int          exp_edge[$];

  int          hits;
  int          arm_edge;
  int          overlap_cnt;
  bit          stopped;
  logic [31:0] win_base_m;
  logic [31:0] win_range_m;

  trace_monitor_top #(
    .PEND_DEPTH(PEND_DEPTH), .BUF_DEPTH(BUF_DEPTH),
    .WIN_BASE_RST(WIN_BASE_DEF), .WIN_RANGE_RST(WIN_RANGE_DEF)
  ) uut (
    .clk_i(clk), .rst_i(rst), .req_i(req), .adr_i(adr), .d_i(d), .we_i(we),
    .size_i(size), .sp_i(sp), .ra_i(ra), .ack_i(ack), .q_i(q),
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
    .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack), .irq_o(irq)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Edge counter and watchdog
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("Run stopped: no end of test after %0d cycles", MAX_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Checks and Wishbone access
  //////////////////////////////////////////////////

  task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Classic cycle, ack_edge is the edge that raised ack
  task automatic wb_write(input logic [3:0] a, input logic [31:0] v, output int ack_edge);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= a;
    wb_dat_w <= v;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    ack_edge = cycle_cnt;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_read(input logic [3:0] a, output logic [31:0] v);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= a;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    v = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic set_window(input logic [31:0] base, input logic [31:0] range);
    int unused_edge;
    wb_write(REG_WIN_BASE, base, unused_edge);
    wb_write(REG_WIN_RANGE, range, unused_edge);
    win_base_m  = base;
    win_range_m = range;
  endtask

  // Arm clears count, dropped and time at the ack edge
  task automatic arm_trace();
    wb_write(REG_CTRL, 32'h1, arm_edge);
    hits    = 0;
    stopped = 1'b0;
    exp_adr.delete();
    exp_data.delete();
    exp_sp.delete();
    exp_ra.delete();
    exp_flags.delete();
    exp_edge.delete();
  endtask

  //////////////////////////////////////////////////
  // Reference model and bus traffic
  //////////////////////////////////////////////////

  function automatic bit in_window(input logic [31:0] a);
    logic [32:0] lim;
    lim = {1'b0, win_base_m} + {1'b0, win_range_m};
    return (a >= win_base_m) && ({1'b0, a} < lim);
  endfunction

  // Oldest request completes, only the first BUF_DEPTH hits are kept
  task automatic model_ack(input logic [31:0] qv, input int ack_edge);
    logic [31:0] a;
    logic [31:0] dv;
    logic        w;
    logic [1:0]  sz;
    logic [31:0] s_p;
    logic [31:0] r_a;
    a   = pend_adr.pop_front();
    dv  = pend_d.pop_front();
    w   = pend_we.pop_front();
    sz  = pend_size.pop_front();
    s_p = pend_sp.pop_front();
    r_a = pend_ra.pop_front();
    void'(pend_due.pop_front());
    if (in_window(a)) begin
      if (hits < BUF_DEPTH) begin
        exp_adr.push_back(a);
        exp_data.push_back(w ? dv : qv);
        exp_sp.push_back(s_p);
        exp_ra.push_back(r_a);
        exp_flags.push_back({sz, w});
        exp_edge.push_back(ack_edge);
      end
      hits++;
    end
  endtask

  // Requests for n_cycles, then drain every outstanding ack
  task automatic run_traffic(input int n_cycles, input int req_pct);
    int          cyc;
    int          now;
    logic        do_ack;
    logic        do_req;
    logic [31:0] a;
    logic [31:0] dv;
    logic [31:0] qv;
    logic [31:0] s_p;
    logic [31:0] r_a;
    logic        w;
    logic [1:0]  sz;
    cyc = 0;
    while (cyc < n_cycles || pend_adr.size() > 0) begin
      @(posedge clk);
      // Values driven now are sampled at the next edge
      now    = cycle_cnt;
      do_ack = (pend_due.size() > 0) && (pend_due[0] <= now);
      do_req = (cyc < n_cycles) && (($urandom % 100) < req_pct)
               && ((pend_adr.size() - int'(do_ack)) < PEND_DEPTH);
      // Mostly low addresses, some anywhere
      a   = (($urandom % 4) == 0) ? $urandom : ($urandom & 32'h0000_1ffc);
      dv  = $urandom;
      qv  = $urandom;
      s_p = $urandom;
      r_a = $urandom;
      w   = 1'($urandom % 2);
      sz  = 2'($urandom_range(2, 0));
      if (do_ack) begin
        model_ack(qv, now + 2);
      end
      if (do_req) begin
        pend_adr.push_back(a);
        pend_d.push_back(dv);
        pend_we.push_back(w);
        pend_size.push_back(sz);
        pend_sp.push_back(s_p);
        pend_ra.push_back(r_a);
        pend_due.push_back(now + int'($urandom_range(3, 1)));
      end
      if (do_req && do_ack) begin
        overlap_cnt++;
      end
      req  <= do_req;
      ack  <= do_ack;
      adr  <= a;
      d    <= dv;
      q    <= qv;
      sp   <= s_p;
      ra   <= r_a;
      we   <= w;
      size <= biu_size_t'(sz);
      cyc++;
    end
    @(posedge clk);
    req <= 1'b0;
    ack <= 1'b0;
  endtask

  // Status, interrupt and every stored record against the model
  task automatic verify_trace(input string tag);
    logic [31:0]  st;
    logic [31:0]  v;
    logic [31:0]  prev_stamp;
    int           n_keep;
    int           i;
    int           unused_edge;
    trace_state_t exp_state;
    n_keep = (hits < BUF_DEPTH) ? hits : BUF_DEPTH;
    if (stopped) begin
      exp_state = IDLE;
    end else begin
      exp_state = (hits >= BUF_DEPTH) ? FULL : CAPTURE;
    end
    wb_read(REG_STATUS, st);
    compare(32'(st[1:0]), 32'(exp_state), $sformatf("%s state", tag));
    compare(32'(st[2]), 32'd0, $sformatf("%s wrapped", tag));
    compare(32'(st[15:8]), 32'(n_keep), $sformatf("%s count", tag));
    compare(32'(st[31:16]), 32'(hits - n_keep), $sformatf("%s dropped", tag));
    compare(32'(irq), 32'(exp_state == FULL), $sformatf("%s irq", tag));
    prev_stamp = '0;
    for (i = 0; i < n_keep; i++) begin
      wb_write(REG_RD_INDEX, 32'(i), unused_edge);
      wb_read(REG_REC_ADR, v);
      compare(v, exp_adr[i], $sformatf("%s rec %0d adr", tag, i));
      wb_read(REG_REC_DATA, v);
      compare(v, exp_data[i], $sformatf("%s rec %0d data", tag, i));
      wb_read(REG_REC_SP, v);
      compare(v, exp_sp[i], $sformatf("%s rec %0d sp", tag, i));
      wb_read(REG_REC_RA, v);
      compare(v, exp_ra[i], $sformatf("%s rec %0d ra", tag, i));
      wb_read(REG_REC_FLAGS, v);
      compare(v, 32'(exp_flags[i]), $sformatf("%s rec %0d flags", tag, i));
      wb_read(REG_REC_STAMP, v);
      if (i == 0) begin
        // One count per cycle after the arm edge
        compare(v, 32'(exp_edge[0] - arm_edge - 1),
                $sformatf("%s first stamp after clear", tag));
      end else begin
        compare(v - prev_stamp, 32'(exp_edge[i] - exp_edge[i-1]),
                $sformatf("%s rec %0d stamp step", tag, i));
      end
      prev_stamp = v;
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] v;
    int          stop_edge;
    void'($urandom(32'hd6d1));
    cycle_cnt   = 0;
    errors      = 0;
    hits        = 0;
    arm_edge    = 0;
    overlap_cnt = 0;
    stopped     = 1'b1;
    win_base_m  = WIN_BASE_DEF;
    win_range_m = WIN_RANGE_DEF;
    rst      <= 1'b1;
    req      <= 1'b0;
    adr      <= '0;
    d        <= '0;
    we       <= 1'b0;
    size     <= BYTE;
    sp       <= '0;
    ra       <= '0;
    ack      <= 1'b0;
    q        <= '0;
    wb_cyc   <= 1'b0;
    wb_stb   <= 1'b0;
    wb_we    <= 1'b0;
    wb_adr   <= '0;
    wb_dat_w <= '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    // Reset values
    wb_read(REG_STATUS, v);
    compare(v, 32'h0, "reset status");
    wb_read(REG_WIN_BASE, v);
    compare(v, WIN_BASE_DEF, "reset window base");
    wb_read(REG_WIN_RANGE, v);
    compare(v, WIN_RANGE_DEF, "reset window range");
    compare(32'(irq), 32'd0, "reset irq");

    // Capture and readout with the default window
    arm_trace();
    run_traffic(T_CAPTURE, 40);
    verify_trace("capture");

    // Narrow window
    set_window(32'h0000_1000, 32'h0000_0800);
    arm_trace();
    run_traffic(T_WINDOW, 50);
    verify_trace("window");

    // Dense traffic, req and ack in the same cycle
    overlap_cnt = 0;
    arm_trace();
    run_traffic(T_OVERLAP, 90);
    compare(32'(overlap_cnt > 0), 32'd1, "overlap seen");
    verify_trace("overlap");

    // Overflow the buffer
    set_window(32'h0000_0000, 32'hffff_ffff);
    arm_trace();
    run_traffic(T_FULL, 80);
    compare(32'(hits > BUF_DEPTH), 32'd1, "enough hits to overflow");
    verify_trace("full");

    // Stop keeps records and drop count
    wb_write(REG_CTRL, 32'h2, stop_edge);
    stopped = 1'b1;
    verify_trace("stopped");

    // Rearm starts over
    set_window(32'h0000_0800, 32'h0000_1000);
    arm_trace();
    verify_trace("rearm empty");
    run_traffic(T_REARM, 50);
    verify_trace("rearm");

    $display("Checks done with %0d errors", errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* logic/trace_monitor_top.sv */
/*
 * Data bus access tracer
 * Captures windowed bus accesses with timestamps, read out over Wishbone
 */

`timescale 1ns/10ps

module trace_monitor_top #(
  parameter int                         PEND_DEPTH    = 4,
  parameter int                         BUF_DEPTH     = 16,
  parameter logic [trace_pkg::XLEN-1:0] WIN_BASE_RST  = 32'h0000_0000,
  parameter logic [trace_pkg::XLEN-1:0] WIN_RANGE_RST = 32'h0000_4000
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  // Observed data bus
  input  logic                        req_i,
  input  logic [trace_pkg::XLEN-1:0]  adr_i,
  input  logic [trace_pkg::XLEN-1:0]  d_i,
  input  logic                        we_i,
  input  trace_pkg::biu_size_t        size_i,
  input  logic [trace_pkg::XLEN-1:0]  sp_i,
  input  logic [trace_pkg::XLEN-1:0]  ra_i,
  input  logic                        ack_i,
  input  logic [trace_pkg::XLEN-1:0]  q_i,
  // Wishbone slave
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  logic [trace_pkg::WB_AW-1:0] wb_adr_i,
  input  logic [trace_pkg::XLEN-1:0]  wb_dat_i,
  output logic [trace_pkg::XLEN-1:0]  wb_dat_o,
  output logic                        wb_ack_o,
  output logic                        irq_o
);
  import trace_pkg::*;

  localparam int IDX_W = $clog2(BUF_DEPTH);
  localparam int CNT_W = $clog2(BUF_DEPTH + 1);

  trace_rec_if rec ();

  logic [XLEN-1:0]    win_base;
  logic [XLEN-1:0]    win_range;
  logic               arm;
  logic               stop;
  logic               buf_wr;
  logic               buf_clear;
  trace_state_t       state;
  logic [DROP_W-1:0]  dropped;
  logic [STAMP_W-1:0] stamp;
  logic               wrapped;
  logic [CNT_W-1:0]   count;
  logic [IDX_W-1:0]   rd_index;
  logic [XLEN-1:0]    rd_adr;
  logic [XLEN-1:0]    rd_data;
  logic [XLEN-1:0]    rd_sp;
  logic [XLEN-1:0]    rd_ra;
  logic [STAMP_W-1:0] rd_stamp;
  logic [FLAGS_W-1:0] rd_flags;

  trace_capture #(.PEND_DEPTH(PEND_DEPTH)) u_capture (
    .clk_i, .rst_i, .req_i, .adr_i, .d_i, .we_i, .size_i, .sp_i, .ra_i,
    .ack_i, .q_i, .win_base_i(win_base), .win_range_i(win_range), .rec(rec.src)
  );

  // Time runs from arm until stop
  trace_stamp_counter u_stamp (
    .clk_i, .rst_i, .clear_i(buf_clear), .run_i(state != IDLE),
    .stamp_o(stamp), .wrapped_o(wrapped)
  );

  trace_ctrl_fsm #(.BUF_DEPTH(BUF_DEPTH)) u_ctrl (
    .clk_i, .rst_i, .arm_i(arm), .stop_i(stop), .rec_valid_i(rec.valid),
    .count_i(count), .buf_wr_o(buf_wr), .buf_clear_o(buf_clear),
    .state_o(state), .dropped_o(dropped), .full_o(irq_o)
  );

  trace_buffer #(.BUF_DEPTH(BUF_DEPTH)) u_buffer (
    .clk_i, .rst_i, .rec(rec.dst), .stamp_i(stamp), .wr_i(buf_wr),
    .clear_i(buf_clear), .rd_index_i(rd_index), .count_o(count),
    .rd_adr_o(rd_adr), .rd_data_o(rd_data), .rd_sp_o(rd_sp), .rd_ra_o(rd_ra),
    .rd_stamp_o(rd_stamp), .rd_flags_o(rd_flags)
  );

  trace_wb_regs #(
    .BUF_DEPTH(BUF_DEPTH), .WIN_BASE_RST(WIN_BASE_RST), .WIN_RANGE_RST(WIN_RANGE_RST)
  ) u_regs (
    .clk_i, .rst_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
    .wb_dat_o, .wb_ack_o, .state_i(state), .count_i(count), .dropped_i(dropped),
    .wrapped_i(wrapped), .rd_adr_i(rd_adr), .rd_data_i(rd_data), .rd_sp_i(rd_sp),
    .rd_ra_i(rd_ra), .rd_stamp_i(rd_stamp), .rd_flags_i(rd_flags),
    .arm_o(arm), .stop_o(stop), .win_base_o(win_base), .win_range_o(win_range),
    .rd_index_o(rd_index)
  );

endmodule

/* logic/trace_wb_regs.sv */
/*
 * Wishbone classic register block
 * Control, status, window setup and readout of the selected record
 */

`timescale 1ns/10ps

module trace_wb_regs #(
  parameter int                         BUF_DEPTH     = 16,
  parameter logic [trace_pkg::XLEN-1:0] WIN_BASE_RST  = 32'h0000_0000,
  parameter logic [trace_pkg::XLEN-1:0] WIN_RANGE_RST = 32'h0000_4000
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           wb_cyc_i,
  input  logic                           wb_stb_i,
  input  logic                           wb_we_i,
  input  logic [trace_pkg::WB_AW-1:0]    wb_adr_i,
  input  logic [trace_pkg::XLEN-1:0]     wb_dat_i,
  output logic [trace_pkg::XLEN-1:0]     wb_dat_o,
  output logic                           wb_ack_o,
  input  trace_pkg::trace_state_t        state_i,
  input  logic [$clog2(BUF_DEPTH+1)-1:0] count_i,
  input  logic [trace_pkg::DROP_W-1:0]   dropped_i,
  input  logic                           wrapped_i,
  input  logic [trace_pkg::XLEN-1:0]     rd_adr_i,
  input  logic [trace_pkg::XLEN-1:0]     rd_data_i,
  input  logic [trace_pkg::XLEN-1:0]     rd_sp_i,
  input  logic [trace_pkg::XLEN-1:0]     rd_ra_i,
  input  logic [trace_pkg::STAMP_W-1:0]  rd_stamp_i,
  input  logic [trace_pkg::FLAGS_W-1:0]  rd_flags_i,
  output logic                           arm_o,
  output logic                           stop_o,
  output logic [trace_pkg::XLEN-1:0]     win_base_o,
  output logic [trace_pkg::XLEN-1:0]     win_range_o,
  output logic [$clog2(BUF_DEPTH)-1:0]   rd_index_o
);
  import trace_pkg::*;

  localparam int IDX_W = $clog2(BUF_DEPTH);

  logic            bus_req;
  logic            bus_wr;
  logic [XLEN-1:0] rd_word;

  // New access, not the one already being acked
  assign bus_req = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign bus_wr  = bus_req && wb_we_i;

  // Command pulses act on the same edge that raises ack
  assign arm_o  = bus_wr && (wb_adr_i == REG_CTRL) && wb_dat_i[0];
  assign stop_o = bus_wr && (wb_adr_i == REG_CTRL) && wb_dat_i[1];

  //////////////////////////////////////////////////
  // Writable registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      win_base_o  <= WIN_BASE_RST;
      win_range_o <= WIN_RANGE_RST;
      rd_index_o  <= '0;
    end else if (bus_wr) begin
      case (wb_adr_i)
        REG_WIN_BASE:  win_base_o  <= wb_dat_i;
        REG_WIN_RANGE: win_range_o <= wb_dat_i;
        // Index wraps modulo the buffer depth
        REG_RD_INDEX:  rd_index_o  <= wb_dat_i[IDX_W-1:0];
        default:       rd_index_o  <= rd_index_o;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Read mux and handshake
  //////////////////////////////////////////////////

  always_comb begin
    rd_word = '0;
    case (wb_adr_i)
      // dropped, count, wrapped, state
      REG_STATUS:    rd_word = {dropped_i, 8'(count_i), 5'd0, wrapped_i, state_i};
      REG_WIN_BASE:  rd_word = win_base_o;
      REG_WIN_RANGE: rd_word = win_range_o;
      REG_RD_INDEX:  rd_word = XLEN'(rd_index_o);
      REG_REC_ADR:   rd_word = rd_adr_i;
      REG_REC_DATA:  rd_word = rd_data_i;
      REG_REC_SP:    rd_word = rd_sp_i;
      REG_REC_RA:    rd_word = rd_ra_i;
      REG_REC_STAMP: rd_word = XLEN'(rd_stamp_i);
      REG_REC_FLAGS: rd_word = XLEN'(rd_flags_i);
      default:       rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= bus_req;
    end
  end

  // Read data is valid with ack
  always_ff @(posedge clk_i) begin
    if (bus_req) begin
      wb_dat_o <= rd_word;
    end
  end

endmodule

/* logic/trace_buffer.sv */
/*
 * Trace record memory
 * Appends records with their stamp and reads any one back by index
 */

`timescale 1ns/10ps

module trace_buffer #(
  parameter int BUF_DEPTH = 16
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  trace_rec_if.dst                       rec,
  input  logic [trace_pkg::STAMP_W-1:0]  stamp_i,
  input  logic                           wr_i,
  input  logic                           clear_i,
  input  logic [$clog2(BUF_DEPTH)-1:0]   rd_index_i,
  output logic [$clog2(BUF_DEPTH+1)-1:0] count_o,
  output logic [trace_pkg::XLEN-1:0]     rd_adr_o,
  output logic [trace_pkg::XLEN-1:0]     rd_data_o,
  output logic [trace_pkg::XLEN-1:0]     rd_sp_o,
  output logic [trace_pkg::XLEN-1:0]     rd_ra_o,
  output logic [trace_pkg::STAMP_W-1:0]  rd_stamp_o,
  output logic [trace_pkg::FLAGS_W-1:0]  rd_flags_o
);
  import trace_pkg::*;

  localparam int IDX_W = $clog2(BUF_DEPTH);

  logic [XLEN-1:0]    adr_mem   [BUF_DEPTH];
  logic [XLEN-1:0]    data_mem  [BUF_DEPTH];
  logic [XLEN-1:0]    sp_mem    [BUF_DEPTH];
  logic [XLEN-1:0]    ra_mem    [BUF_DEPTH];
  logic [STAMP_W-1:0] stamp_mem [BUF_DEPTH];
  logic [FLAGS_W-1:0] flags_mem [BUF_DEPTH];

  logic             wr_en;
  // Next free slot is the record count
  logic [IDX_W-1:0] wr_ptr;

  assign wr_en  = wr_i && rec.valid && !clear_i;
  assign wr_ptr = count_o[IDX_W-1:0];

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      adr_mem[wr_ptr]   <= rec.adr;
      data_mem[wr_ptr]  <= rec.data;
      sp_mem[wr_ptr]    <= rec.sp;
      ra_mem[wr_ptr]    <= rec.ra;
      stamp_mem[wr_ptr] <= stamp_i;
      flags_mem[wr_ptr] <= {rec.size, rec.we};
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      count_o <= '0;
    end else if (wr_en) begin
      count_o <= count_o + 1'b1;
    end
  end

  // Combinational readout for the register block
  assign rd_adr_o   = adr_mem[rd_index_i];
  assign rd_data_o  = data_mem[rd_index_i];
  assign rd_sp_o    = sp_mem[rd_index_i];
  assign rd_ra_o    = ra_mem[rd_index_i];
  assign rd_stamp_o = stamp_mem[rd_index_i];
  assign rd_flags_o = flags_mem[rd_index_i];

endmodule

/* logic/trace_ctrl_fsm.sv */
/*
 * Capture control
 * IDLE, CAPTURE and FULL states, decides which records get stored
 * and counts those lost once the buffer is full
 */

`timescale 1ns/10ps

module trace_ctrl_fsm #(
  parameter int BUF_DEPTH = 16
) (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic                             arm_i,
  input  logic                             stop_i,
  input  logic                             rec_valid_i,
  input  logic [$clog2(BUF_DEPTH+1)-1:0]   count_i,
  output logic                             buf_wr_o,
  output logic                             buf_clear_o,
  output trace_pkg::trace_state_t          state_o,
  output logic [trace_pkg::DROP_W-1:0]     dropped_o,
  output logic                             full_o
);
  import trace_pkg::*;

  localparam int CNT_W = $clog2(BUF_DEPTH + 1);

  // Last free slot being filled in this cycle
  logic last_slot;

  // Store only while capturing, arm takes the cycle for its clear
  assign buf_wr_o    = (state_o == CAPTURE) && rec_valid_i && !arm_i;
  assign buf_clear_o = arm_i;
  assign full_o      = (state_o == FULL);
  assign last_slot   = (count_i == CNT_W'(BUF_DEPTH - 1));

  //////////////////////////////////////////////////
  // State and drop counter
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_o   <= IDLE;
      dropped_o <= '0;
    end else if (arm_i) begin
      // Arm wins over stop and over a pending record
      state_o   <= CAPTURE;
      dropped_o <= '0;
    end else if (stop_i) begin
      // Records stay readable
      state_o <= IDLE;
    end else begin
      case (state_o)
        CAPTURE: begin
          if (buf_wr_o && last_slot) begin
            state_o <= FULL;
          end
        end
        FULL: begin
          // Saturating count of lost records
          if (rec_valid_i && (dropped_o != {DROP_W{1'b1}})) begin
            dropped_o <= dropped_o + 1'b1;
          end
        end
        default: state_o <= state_o;
      endcase
    end
  end

endmodule

/* logic/trace_stamp_counter.sv */
/*
 * Trace timebase
 * Free running stamp while capturing, with a sticky rollover flag
 */

`timescale 1ns/10ps

module trace_stamp_counter (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          clear_i,
  input  logic                          run_i,
  output logic [trace_pkg::STAMP_W-1:0] stamp_o,
  output logic                          wrapped_o
);
  import trace_pkg::*;

  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      // Arm restarts time at zero
      stamp_o   <= '0;
      wrapped_o <= 1'b0;
    end else if (run_i) begin
      stamp_o <= stamp_o + 1'b1;
      // Sticky until the next arm
      if (stamp_o == {STAMP_W{1'b1}}) begin
        wrapped_o <= 1'b1;
      end
    end
  end

endmodule

/* logic/trace_capture.sv */
/*
 * Data bus request capture
 * Queues requests until their in-order ack, then offers the record
 * to the buffer when its address hits the trace window
 */

`timescale 1ns/10ps

module trace_capture #(
  parameter int PEND_DEPTH = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       req_i,
  input  logic [trace_pkg::XLEN-1:0] adr_i,
  input  logic [trace_pkg::XLEN-1:0] d_i,
  input  logic                       we_i,
  input  trace_pkg::biu_size_t       size_i,
  input  logic [trace_pkg::XLEN-1:0] sp_i,
  input  logic [trace_pkg::XLEN-1:0] ra_i,
  input  logic                       ack_i,
  input  logic [trace_pkg::XLEN-1:0] q_i,
  input  logic [trace_pkg::XLEN-1:0] win_base_i,
  input  logic [trace_pkg::XLEN-1:0] win_range_i,
  trace_rec_if.src                   rec
);
  import trace_pkg::*;

  localparam int PTR_W = (PEND_DEPTH > 1) ? $clog2(PEND_DEPTH) : 1;
  localparam int CNT_W = $clog2(PEND_DEPTH + 1);

  // Pending request storage
  logic [XLEN-1:0]  adr_q  [PEND_DEPTH];
  logic [XLEN-1:0]  data_q [PEND_DEPTH];
  logic             we_q   [PEND_DEPTH];
  biu_size_t        size_q [PEND_DEPTH];
  logic [XLEN-1:0]  sp_q   [PEND_DEPTH];
  logic [XLEN-1:0]  ra_q   [PEND_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] pend_cnt;
  logic             pop;
  // One extra bit so base plus range cannot wrap
  logic [XLEN:0]    win_end;
  logic             in_window;

  // Circular increment, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(PEND_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // Stray ack with nothing pending is ignored
  assign pop = ack_i && (pend_cnt != '0);

  //////////////////////////////////////////////////
  // Queue
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      adr_q[wr_ptr]  <= adr_i;
      data_q[wr_ptr] <= d_i;
      we_q[wr_ptr]   <= we_i;
      size_q[wr_ptr] <= size_i;
      sp_q[wr_ptr]   <= sp_i;
      ra_q[wr_ptr]   <= ra_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      pend_cnt <= '0;
    end else begin
      if (req_i) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      // Push and pop together leave the fill level alone
      case ({req_i, pop})
        2'b10:   pend_cnt <= pend_cnt + 1'b1;
        2'b01:   pend_cnt <= pend_cnt - 1'b1;
        default: pend_cnt <= pend_cnt;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Record out
  //////////////////////////////////////////////////

  // Window is [base, base + range)
  assign win_end   = {1'b0, win_base_i} + {1'b0, win_range_i};
  assign in_window = (adr_q[rd_ptr] >= win_base_i) && ({1'b0, adr_q[rd_ptr]} < win_end);

  assign rec.valid = pop && in_window;
  assign rec.adr   = adr_q[rd_ptr];
  // Reads carry the data returned with the ack
  assign rec.data  = we_q[rd_ptr] ? data_q[rd_ptr] : q_i;
  assign rec.we    = we_q[rd_ptr];
  assign rec.size  = size_q[rd_ptr];
  assign rec.sp    = sp_q[rd_ptr];
  assign rec.ra    = ra_q[rd_ptr];

endmodule

/* logic/trace_rec_if.sv */
/*
 * Trace record link
 * One completed, in-window access from capture to the trace buffer
 */

`timescale 1ns/10ps

interface trace_rec_if;
  import trace_pkg::*;

  // High for the single cycle of the matching ack
  logic            valid;
  logic [XLEN-1:0] adr;
  // Write data, or returned data for a read
  logic [XLEN-1:0] data;
  logic            we;
  biu_size_t       size;
  // Core context at request time
  logic [XLEN-1:0] sp;
  logic [XLEN-1:0] ra;

  modport src (output valid, adr, data, we, size, sp, ra);
  modport dst (input  valid, adr, data, we, size, sp, ra);

endinterface

/* logic/trace_pkg.sv */
/*
 * Bus access tracer shared definitions
 * Transfer size and capture state types, widths and register map
 */

package trace_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Data bus word
  localparam int XLEN    = 32;
  // Trace timebase
  localparam int STAMP_W = 32;
  // Dropped record counter, fills STATUS[31:16]
  localparam int DROP_W  = 16;
  // Record flags: size in [2:1], write in [0]
  localparam int FLAGS_W = 3;
  // Wishbone word address
  localparam int WB_AW   = 4;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    BYTE = 2'b00,
    HALF = 2'b01,
    WORD = 2'b10
  } biu_size_t;

  typedef enum logic [1:0] {
    IDLE    = 2'b00,
    CAPTURE = 2'b01,
    FULL    = 2'b10
  } trace_state_t;

  //////////////////////////////////////////////////
  // Register word offsets
  //////////////////////////////////////////////////

  localparam logic [WB_AW-1:0] REG_CTRL      = 4'd0;
  localparam logic [WB_AW-1:0] REG_STATUS    = 4'd1;
  localparam logic [WB_AW-1:0] REG_WIN_BASE  = 4'd2;
  localparam logic [WB_AW-1:0] REG_WIN_RANGE = 4'd3;
  localparam logic [WB_AW-1:0] REG_RD_INDEX  = 4'd4;
  localparam logic [WB_AW-1:0] REG_REC_ADR   = 4'd8;
  localparam logic [WB_AW-1:0] REG_REC_DATA  = 4'd9;
  localparam logic [WB_AW-1:0] REG_REC_SP    = 4'd10;
  localparam logic [WB_AW-1:0] REG_REC_RA    = 4'd11;
  localparam logic [WB_AW-1:0] REG_REC_STAMP = 4'd12;
  localparam logic [WB_AW-1:0] REG_REC_FLAGS = 4'd13;

endpackage
